//--- rooth_cfg.svh
// Width settings shared by the package, the write-back RTL and the testbench
// Include once per compilation unit; the guard makes repeats harmless
`ifndef ROOTH_CFG_SVH
`define ROOTH_CFG_SVH

// CPU data and instruction word
`define CPU_WIDTH 32

// Integer register index
`define REG_ADDR_WIDTH 5

// Machine CSR address
`define CSR_ADDR_WIDTH 12

`endif

//--- verilog/rooth_pkg.sv
// Types and constants for the write-back end, referenced as rooth_pkg::name
`default_nettype none
`include "rooth_cfg.svh"

package rooth_pkg;

    // --------------------
    // Width types
    typedef logic [`CPU_WIDTH-1:0]      cpu_word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // Stage flow command
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'd0,
        FLOW_STOP    = 2'd1,
        FLOW_REFRESH = 2'd2
    } flow_t;

    // --------------------
    // Machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // Writable bits per CSR
    // mstatus keeps MIE (bit 3) and MPIE (bit 7) only
    localparam cpu_word_t MSTATUS_WMASK  = 32'h0000_0088;
    localparam cpu_word_t MTVEC_WMASK    = 32'hFFFF_FFFC;
    localparam cpu_word_t MSCRATCH_WMASK = 32'hFFFF_FFFF;
    localparam cpu_word_t MEPC_WMASK     = 32'hFFFF_FFFC;
    localparam cpu_word_t MCAUSE_WMASK   = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- verilog/flow_ctrl.sv
// Resolves stall and flush requests into the write-back flow command
// and counts instructions retired into write-back
`timescale 1ns/1ns
`default_nettype none

module flow_ctrl (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                stall_req_i,
    input  wire                flush_req_i,
    input  rooth_pkg::cpu_word_t inst_i,
    output rooth_pkg::flow_t   flow_wb_o,
    output rooth_pkg::cpu_word_t retire_cnt_o
);

    logic                 retire;
    rooth_pkg::cpu_word_t retire_cnt;

    // --------------------
    // Flush has priority over stall
    always_comb begin
        if (flush_req_i) begin
            flow_wb_o = rooth_pkg::FLOW_REFRESH;
        end else if (stall_req_i) begin
            flow_wb_o = rooth_pkg::FLOW_STOP;
        end else begin
            flow_wb_o = rooth_pkg::FLOW_WORK;
        end
    end

    // A real instruction loaded into the stage retires
    assign retire = (flow_wb_o == rooth_pkg::FLOW_WORK) && (inst_i != '0);

    // --------------------
    // Instret source
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_cnt <= '0;
        end else if (retire) begin
            retire_cnt <= retire_cnt + 1'b1;
        end
    end

    assign retire_cnt_o = retire_cnt;

endmodule

`default_nettype wire

//--- verilog/if_wb.sv
// Stage register between memory access and write-back
// Driven by the flow command: work loads, stop holds, refresh clears
`timescale 1ns/1ns
`default_nettype none

module if_wb (
    input  wire                  clk,
    input  wire                  rst_n,
    input  rooth_pkg::flow_t     flow_wb_i,
    input  rooth_pkg::cpu_word_t inst_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  wire                  reg_wr_en_i,
    input  rooth_pkg::reg_addr_t reg_wr_addr_i,
    input  rooth_pkg::cpu_word_t reg_wr_data_i,
    input  wire                  csr_wr_en_i,
    input  rooth_pkg::csr_addr_t csr_wr_addr_i,
    input  rooth_pkg::cpu_word_t csr_wr_data_i,
    output rooth_pkg::cpu_word_t inst_o,
    output rooth_pkg::cpu_word_t pc_o,
    output logic                 reg_wr_en_o,
    output rooth_pkg::reg_addr_t reg_wr_addr_o,
    output rooth_pkg::cpu_word_t reg_wr_data_o,
    output logic                 csr_wr_en_o,
    output rooth_pkg::csr_addr_t csr_wr_addr_o,
    output rooth_pkg::cpu_word_t csr_wr_data_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_o        <= '0;
            pc_o          <= '0;
            reg_wr_en_o   <= 1'b0;
            reg_wr_addr_o <= '0;
            reg_wr_data_o <= '0;
            csr_wr_en_o   <= 1'b0;
            csr_wr_addr_o <= '0;
            csr_wr_data_o <= '0;
        end else begin
            case (flow_wb_i)
                rooth_pkg::FLOW_WORK: begin
                    inst_o        <= inst_i;
                    pc_o          <= pc_i;
                    reg_wr_en_o   <= reg_wr_en_i;
                    reg_wr_addr_o <= reg_wr_addr_i;
                    reg_wr_data_o <= reg_wr_data_i;
                    csr_wr_en_o   <= csr_wr_en_i;
                    csr_wr_addr_o <= csr_wr_addr_i;
                    csr_wr_data_o <= csr_wr_data_i;
                end
                rooth_pkg::FLOW_STOP: begin
                    // Held write enables just rewrite the same value
                end
                default: begin
                    // Refresh, or an undefined command, turns the stage into a bubble
                    inst_o        <= '0;
                    pc_o          <= '0;
                    reg_wr_en_o   <= 1'b0;
                    reg_wr_addr_o <= '0;
                    reg_wr_data_o <= '0;
                    csr_wr_en_o   <= 1'b0;
                    csr_wr_addr_o <= '0;
                    csr_wr_data_o <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
// Integer register file, x0 reads as zero
// One write port from write-back, one read port with write bypass
`timescale 1ns/1ns
`default_nettype none
`include "rooth_cfg.svh"

module reg_file (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr_en_i,
    input  rooth_pkg::reg_addr_t wr_addr_i,
    input  rooth_pkg::cpu_word_t wr_data_i,
    input  rooth_pkg::reg_addr_t rd_addr_i,
    output rooth_pkg::cpu_word_t rd_data_o
);

    localparam int REG_NUM = 1 << `REG_ADDR_WIDTH;

    rooth_pkg::cpu_word_t regs [REG_NUM];
    logic                 wr_hit;

    // --------------------
    // Write port, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // --------------------
    // Read port
    // Pending write to the same register is forwarded
    assign wr_hit = wr_en_i && (wr_addr_i == rd_addr_i);

    always_comb begin
        if (rd_addr_i == '0) begin
            rd_data_o = '0;
        end else if (wr_hit) begin
            rd_data_o = wr_data_i;
        end else begin
            rd_data_o = regs[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
// Machine CSR file with mstatus, mtvec, mscratch, mepc and mcause
// Writes are masked per register; unknown addresses read as zero
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr_en_i,
    input  rooth_pkg::csr_addr_t wr_addr_i,
    input  rooth_pkg::cpu_word_t wr_data_i,
    input  rooth_pkg::csr_addr_t rd_addr_i,
    output rooth_pkg::cpu_word_t rd_data_o
);

    rooth_pkg::cpu_word_t mstatus;
    rooth_pkg::cpu_word_t mtvec;
    rooth_pkg::cpu_word_t mscratch;
    rooth_pkg::cpu_word_t mepc;
    rooth_pkg::cpu_word_t mcause;

    // --------------------
    // Write decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (wr_en_i) begin
            case (wr_addr_i)
                rooth_pkg::CSR_MSTATUS:  mstatus  <= wr_data_i & rooth_pkg::MSTATUS_WMASK;
                rooth_pkg::CSR_MTVEC:    mtvec    <= wr_data_i & rooth_pkg::MTVEC_WMASK;
                rooth_pkg::CSR_MSCRATCH: mscratch <= wr_data_i & rooth_pkg::MSCRATCH_WMASK;
                rooth_pkg::CSR_MEPC:     mepc     <= wr_data_i & rooth_pkg::MEPC_WMASK;
                rooth_pkg::CSR_MCAUSE:   mcause   <= wr_data_i & rooth_pkg::MCAUSE_WMASK;
                default: begin
                    // Unimplemented CSR, write dropped
                end
            endcase
        end
    end

    // --------------------
    // Read decode
    always_comb begin
        case (rd_addr_i)
            rooth_pkg::CSR_MSTATUS:  rd_data_o = mstatus;
            rooth_pkg::CSR_MTVEC:    rd_data_o = mtvec;
            rooth_pkg::CSR_MSCRATCH: rd_data_o = mscratch;
            rooth_pkg::CSR_MEPC:     rd_data_o = mepc;
            rooth_pkg::CSR_MCAUSE:   rd_data_o = mcause;
            default:                 rd_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/wb_top.sv
// Write-back end of the pipeline: flow control, stage register and
// the integer and CSR files, with one observation read port each
`timescale 1ns/1ns
`default_nettype none

module wb_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  rooth_pkg::cpu_word_t inst_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  wire                  reg_wr_en_i,
    input  rooth_pkg::reg_addr_t reg_wr_addr_i,
    input  rooth_pkg::cpu_word_t reg_wr_data_i,
    input  wire                  csr_wr_en_i,
    input  rooth_pkg::csr_addr_t csr_wr_addr_i,
    input  rooth_pkg::cpu_word_t csr_wr_data_i,
    input  wire                  stall_req_i,
    input  wire                  flush_req_i,
    input  rooth_pkg::reg_addr_t reg_rd_addr_i,
    input  rooth_pkg::csr_addr_t csr_rd_addr_i,
    output rooth_pkg::cpu_word_t reg_rd_data_o,
    output rooth_pkg::cpu_word_t csr_rd_data_o,
    output rooth_pkg::cpu_word_t inst_o,
    output rooth_pkg::cpu_word_t pc_o,
    output rooth_pkg::cpu_word_t retire_cnt_o
);

    rooth_pkg::flow_t     flow_wb;

    // Stage outputs towards the register files
    logic                 wb_reg_wr_en;
    rooth_pkg::reg_addr_t wb_reg_wr_addr;
    rooth_pkg::cpu_word_t wb_reg_wr_data;
    logic                 wb_csr_wr_en;
    rooth_pkg::csr_addr_t wb_csr_wr_addr;
    rooth_pkg::cpu_word_t wb_csr_wr_data;

    flow_ctrl u_flow_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_req_i  (stall_req_i),
        .flush_req_i  (flush_req_i),
        .inst_i       (inst_i),
        .flow_wb_o    (flow_wb),
        .retire_cnt_o (retire_cnt_o)
    );

    if_wb u_if_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .flow_wb_i     (flow_wb),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .reg_wr_en_i   (reg_wr_en_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_data_i (reg_wr_data_i),
        .csr_wr_en_i   (csr_wr_en_i),
        .csr_wr_addr_i (csr_wr_addr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .reg_wr_en_o   (wb_reg_wr_en),
        .reg_wr_addr_o (wb_reg_wr_addr),
        .reg_wr_data_o (wb_reg_wr_data),
        .csr_wr_en_o   (wb_csr_wr_en),
        .csr_wr_addr_o (wb_csr_wr_addr),
        .csr_wr_data_o (wb_csr_wr_data)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wb_reg_wr_en),
        .wr_addr_i (wb_reg_wr_addr),
        .wr_data_i (wb_reg_wr_data),
        .rd_addr_i (reg_rd_addr_i),
        .rd_data_o (reg_rd_data_o)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wb_csr_wr_en),
        .wr_addr_i (wb_csr_wr_addr),
        .wr_data_i (wb_csr_wr_data),
        .rd_addr_i (csr_rd_addr_i),
        .rd_data_o (csr_rd_data_o)
    );

endmodule

`default_nettype wire

//--- dv/wb_assert.sv
// Concurrent checks on the flow command and the stage register outputs
// Bound into wb_top, where the flow wire and stage write enables are visible
`timescale 1ns/1ns
`default_nettype none

module wb_assert (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  flush_req_i,
    input  rooth_pkg::flow_t     flow_i,
    input  rooth_pkg::cpu_word_t inst_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  wire                  reg_wr_en_i,
    input  wire                  csr_wr_en_i,
    input  rooth_pkg::cpu_word_t retire_cnt_i
);

    // Failed assertions, read back by the testbench at the end
    int fail_cnt = 0;

    flush_gives_refresh: assert property (@(posedge clk) disable iff (!rst_n)
        flush_req_i |-> (flow_i == rooth_pkg::FLOW_REFRESH))
    else begin
        $error("flush request did not produce a refresh command");
        fail_cnt++;
    end

    refresh_clears_stage: assert property (@(posedge clk) disable iff (!rst_n)
        (flow_i == rooth_pkg::FLOW_REFRESH) |=>
        (inst_i == '0) && (pc_i == '0) && !reg_wr_en_i && !csr_wr_en_i)
    else begin
        $error("stage not cleared after refresh");
        fail_cnt++;
    end

    stop_holds_stage: assert property (@(posedge clk) disable iff (!rst_n)
        (flow_i == rooth_pkg::FLOW_STOP) |=> $stable(inst_i) && $stable(pc_i))
    else begin
        $error("stage changed under stop");
        fail_cnt++;
    end

    // Instret only moves forward
    retire_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        retire_cnt_i >= $past(retire_cnt_i))
    else begin
        $error("retire count decreased");
        fail_cnt++;
    end

endmodule

bind wb_top wb_assert u_wb_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_req_i  (flush_req_i),
    .flow_i       (flow_wb),
    .inst_i       (inst_o),
    .pc_i         (pc_o),
    .reg_wr_en_i  (wb_reg_wr_en),
    .csr_wr_en_i  (wb_csr_wr_en),
    .retire_cnt_i (retire_cnt_o)
);

`default_nettype wire

//--- dv/wb_checker.sv
// Reference model of the write-back end, compared with the DUT at every rising edge
// Also checks the read values that the stimulus table expects
`timescale 1ns/1ns
`default_nettype none
`include "rooth_cfg.svh"

module wb_checker (
    input  wire                  clk,
    input  wire                  rst_n,
    input  rooth_pkg::cpu_word_t inst_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  wire                  reg_wr_en_i,
    input  rooth_pkg::reg_addr_t reg_wr_addr_i,
    input  rooth_pkg::cpu_word_t reg_wr_data_i,
    input  wire                  csr_wr_en_i,
    input  rooth_pkg::csr_addr_t csr_wr_addr_i,
    input  rooth_pkg::cpu_word_t csr_wr_data_i,
    input  wire                  stall_req_i,
    input  wire                  flush_req_i,
    input  rooth_pkg::reg_addr_t reg_rd_addr_i,
    input  rooth_pkg::csr_addr_t csr_rd_addr_i,
    input  rooth_pkg::cpu_word_t reg_rd_data_i,
    input  rooth_pkg::cpu_word_t csr_rd_data_i,
    input  rooth_pkg::cpu_word_t dut_inst_i,
    input  rooth_pkg::cpu_word_t dut_pc_i,
    input  rooth_pkg::cpu_word_t retire_cnt_i,
    input  wire                  exp_valid_i,
    input  rooth_pkg::cpu_word_t exp_reg_i,
    input  rooth_pkg::cpu_word_t exp_csr_i,
    output int                   check_cnt_o,
    output int                   err_cnt_o
);

    localparam int REG_NUM = 1 << `REG_ADDR_WIDTH;

    rooth_pkg::cpu_word_t m_regs [REG_NUM];
    rooth_pkg::cpu_word_t m_csrs [5];
    rooth_pkg::cpu_word_t m_inst;
    rooth_pkg::cpu_word_t m_pc;
    logic                 m_rwe;
    rooth_pkg::reg_addr_t m_rwa;
    rooth_pkg::cpu_word_t m_rwd;
    logic                 m_cwe;
    rooth_pkg::csr_addr_t m_cwa;
    rooth_pkg::cpu_word_t m_cwd;
    rooth_pkg::cpu_word_t m_retire;
    rooth_pkg::cpu_word_t reg_exp;
    int                   slot;

    // Slot of an implemented CSR, -1 when the address is unknown
    function automatic int csr_slot(input rooth_pkg::csr_addr_t addr);
        case (addr)
            12'h300: return 0;
            12'h305: return 1;
            12'h340: return 2;
            12'h341: return 3;
            12'h342: return 4;
            default: return -1;
        endcase
    endfunction

    function automatic rooth_pkg::cpu_word_t csr_mask(input int idx);
        case (idx)
            0:       return 32'h0000_0088;
            1, 3:    return 32'hFFFF_FFFC;
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic compare(input string name, input rooth_pkg::cpu_word_t got,
                           input rooth_pkg::cpu_word_t exp);
        check_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------
    // Compare the state before the edge, then advance the model
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                m_regs[i] = '0;
            end
            for (int i = 0; i < 5; i++) begin
                m_csrs[i] = '0;
            end
            m_inst   = '0;
            m_pc     = '0;
            m_rwe    = 1'b0;
            m_rwa    = '0;
            m_rwd    = '0;
            m_cwe    = 1'b0;
            m_cwa    = '0;
            m_cwd    = '0;
            m_retire = '0;
        end else begin
            // x0 is zero, a write waiting in the stage is forwarded
            if (reg_rd_addr_i == '0) begin
                reg_exp = '0;
            end else if (m_rwe && (m_rwa == reg_rd_addr_i)) begin
                reg_exp = m_rwd;
            end else begin
                reg_exp = m_regs[reg_rd_addr_i];
            end
            slot = csr_slot(csr_rd_addr_i);
            compare("inst_o", dut_inst_i, m_inst);
            compare("pc_o", dut_pc_i, m_pc);
            compare("retire_cnt_o", retire_cnt_i, m_retire);
            compare("reg_rd_data_o", reg_rd_data_i, reg_exp);
            compare("csr_rd_data_o", csr_rd_data_i, (slot < 0) ? '0 : m_csrs[slot]);
            if (exp_valid_i) begin
                compare("reg_rd_data_o (table)", reg_rd_data_i, exp_reg_i);
                compare("csr_rd_data_o (table)", csr_rd_data_i, exp_csr_i);
            end

            // Commit whatever the stage shows, stop or not
            if (m_rwe && (m_rwa != '0)) begin
                m_regs[m_rwa] = m_rwd;
            end
            slot = csr_slot(m_cwa);
            if (m_cwe && (slot >= 0)) begin
                m_csrs[slot] = m_cwd & csr_mask(slot);
            end

            if (flush_req_i) begin
                m_inst = '0;
                m_pc   = '0;
                m_rwe  = 1'b0;
                m_rwa  = '0;
                m_rwd  = '0;
                m_cwe  = 1'b0;
                m_cwa  = '0;
                m_cwd  = '0;
            end else if (!stall_req_i) begin
                m_inst = inst_i;
                m_pc   = pc_i;
                m_rwe  = reg_wr_en_i;
                m_rwa  = reg_wr_addr_i;
                m_rwd  = reg_wr_data_i;
                m_cwe  = csr_wr_en_i;
                m_cwa  = csr_wr_addr_i;
                m_cwd  = csr_wr_data_i;
                if (inst_i != '0) begin
                    m_retire = m_retire + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_wb_top.sv
// Testbench for the write-back end: clock, reset, stimulus table and final report
// Rows are driven on the falling edge and checked by wb_checker at the rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_wb_top;

    localparam int RST_CYCLES = 8;
    localparam rooth_pkg::cpu_word_t INS_A = 32'h0000_0013;
    localparam rooth_pkg::cpu_word_t INS_B = 32'h0010_0093;

    // One stimulus row with the read values expected before the next rising edge
    typedef struct packed {
        rooth_pkg::cpu_word_t inst;
        logic                 reg_we;
        rooth_pkg::reg_addr_t reg_wa;
        rooth_pkg::cpu_word_t reg_wd;
        logic                 csr_we;
        rooth_pkg::csr_addr_t csr_wa;
        rooth_pkg::cpu_word_t csr_wd;
        logic [1:0]           sf;
        rooth_pkg::reg_addr_t reg_ra;
        rooth_pkg::cpu_word_t exp_reg;
        rooth_pkg::csr_addr_t csr_ra;
        rooth_pkg::cpu_word_t exp_csr;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    rooth_pkg::cpu_word_t inst;
    rooth_pkg::cpu_word_t pc;
    logic                 reg_we;
    rooth_pkg::reg_addr_t reg_wa;
    rooth_pkg::cpu_word_t reg_wd;
    logic                 csr_we;
    rooth_pkg::csr_addr_t csr_wa;
    rooth_pkg::cpu_word_t csr_wd;
    logic                 stall;
    logic                 flush;
    rooth_pkg::reg_addr_t reg_ra;
    rooth_pkg::csr_addr_t csr_ra;
    rooth_pkg::cpu_word_t reg_rd;
    rooth_pkg::cpu_word_t csr_rd;
    rooth_pkg::cpu_word_t inst_q;
    rooth_pkg::cpu_word_t pc_q;
    rooth_pkg::cpu_word_t retire_cnt;
    logic                 exp_valid;
    rooth_pkg::cpu_word_t exp_reg;
    rooth_pkg::cpu_word_t exp_csr;
    int                   check_cnt;
    int                   err_cnt;
    row_t                 rows[$];
    int                   num_rows = 0;

    wb_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_i        (inst),
        .pc_i          (pc),
        .reg_wr_en_i   (reg_we),
        .reg_wr_addr_i (reg_wa),
        .reg_wr_data_i (reg_wd),
        .csr_wr_en_i   (csr_we),
        .csr_wr_addr_i (csr_wa),
        .csr_wr_data_i (csr_wd),
        .stall_req_i   (stall),
        .flush_req_i   (flush),
        .reg_rd_addr_i (reg_ra),
        .csr_rd_addr_i (csr_ra),
        .reg_rd_data_o (reg_rd),
        .csr_rd_data_o (csr_rd),
        .inst_o        (inst_q),
        .pc_o          (pc_q),
        .retire_cnt_o  (retire_cnt)
    );

    wb_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_i        (inst),
        .pc_i          (pc),
        .reg_wr_en_i   (reg_we),
        .reg_wr_addr_i (reg_wa),
        .reg_wr_data_i (reg_wd),
        .csr_wr_en_i   (csr_we),
        .csr_wr_addr_i (csr_wa),
        .csr_wr_data_i (csr_wd),
        .stall_req_i   (stall),
        .flush_req_i   (flush),
        .reg_rd_addr_i (reg_ra),
        .csr_rd_addr_i (csr_ra),
        .reg_rd_data_i (reg_rd),
        .csr_rd_data_i (csr_rd),
        .dut_inst_i    (inst_q),
        .dut_pc_i      (pc_q),
        .retire_cnt_i  (retire_cnt),
        .exp_valid_i   (exp_valid),
        .exp_reg_i     (exp_reg),
        .exp_csr_i     (exp_csr),
        .check_cnt_o   (check_cnt),
        .err_cnt_o     (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Table helpers

    // Argument order follows the row_t field order
    task automatic add_row(
        input rooth_pkg::cpu_word_t inst_v,
        input logic                 rwe,
        input rooth_pkg::reg_addr_t rwa,
        input rooth_pkg::cpu_word_t rwd,
        input logic                 cwe,
        input rooth_pkg::csr_addr_t cwa,
        input rooth_pkg::cpu_word_t cwd,
        input logic [1:0]           sf,
        input rooth_pkg::reg_addr_t rra,
        input rooth_pkg::cpu_word_t xreg,
        input rooth_pkg::csr_addr_t cra,
        input rooth_pkg::cpu_word_t xcsr
    );
        rows.push_back({inst_v, rwe, rwa, rwd, cwe, cwa, cwd, sf, rra, xreg, cra, xcsr});
    endtask

    task automatic build_table();
        rooth_pkg::cpu_word_t a;
        rooth_pkg::cpu_word_t b;
        rooth_pkg::cpu_word_t c;
        rooth_pkg::cpu_word_t d;
        rooth_pkg::cpu_word_t e;
        a = $urandom;
        b = $urandom;
        c = $urandom;
        d = $urandom;
        e = $urandom;
        // sf column is {stall, flush}
        // Register write, bypass from the stage, then committed; x0 stays zero
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd5, '0, 12'h300, '0);
        add_row(INS_A, 1'b1, 5'd5, a,  1'b0, 12'h000, '0, 2'b00, 5'd5, '0, 12'h300, '0);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd5, a,  12'h300, '0);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd5, a,  12'h305, '0);
        add_row(INS_A, 1'b1, 5'd0, b,  1'b0, 12'h000, '0, 2'b00, 5'd0, '0, 12'h300, '0);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd0, '0, 12'h300, '0);
        // Masked CSR writes and an unknown address
        add_row(INS_A, 1'b0, 5'd0, '0, 1'b1, 12'h300, '1, 2'b00, 5'd5, a,  12'h300, '0);
        add_row(INS_A, 1'b0, 5'd0, '0, 1'b1, 12'h341, '1, 2'b00, 5'd5, a,  12'h300, '0);
        add_row(INS_A, 1'b0, 5'd0, '0, 1'b1, 12'h7FF, '1, 2'b00, 5'd5, a,  12'h300, 32'h88);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd5, a,  12'h341, 32'hFFFF_FFFC);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd5, a,  12'h7FF, '0);
        // Two stalled cycles, the waiting instruction retires once
        add_row(INS_A, 1'b1, 5'd6, c,  1'b0, 12'h000, '0, 2'b00, 5'd6, '0, 12'h300, 32'h88);
        add_row(INS_B, 1'b1, 5'd7, d,  1'b0, 12'h000, '0, 2'b10, 5'd6, c,  12'h300, 32'h88);
        add_row(INS_B, 1'b1, 5'd7, d,  1'b0, 12'h000, '0, 2'b10, 5'd6, c,  12'h300, 32'h88);
        add_row(INS_B, 1'b1, 5'd7, d,  1'b0, 12'h000, '0, 2'b00, 5'd7, '0, 12'h300, 32'h88);
        add_row(INS_A, 1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd7, d,  12'h300, 32'h88);
        // Flush with stall drops the incoming write to x7
        add_row(INS_A, 1'b1, 5'd7, e,  1'b0, 12'h000, '0, 2'b11, 5'd7, d,  12'h341, 32'hFFFF_FFFC);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd7, d,  12'h341, 32'hFFFF_FFFC);
        add_row('0,    1'b0, 5'd0, '0, 1'b0, 12'h000, '0, 2'b00, 5'd7, d,  12'h300, 32'h88);
    endtask

    task automatic clear_inputs();
        inst      = '0;
        pc        = '0;
        reg_we    = 1'b0;
        reg_wa    = '0;
        reg_wd    = '0;
        csr_we    = 1'b0;
        csr_wa    = '0;
        csr_wd    = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        reg_ra    = '0;
        csr_ra    = '0;
        exp_valid = 1'b0;
        exp_reg   = '0;
        exp_csr   = '0;
    endtask

    task automatic drive_row(input int k);
        inst          = rows[k].inst;
        pc            = 32'h0000_1000 + 32'(k * 4);
        reg_we        = rows[k].reg_we;
        reg_wa        = rows[k].reg_wa;
        reg_wd        = rows[k].reg_wd;
        csr_we        = rows[k].csr_we;
        csr_wa        = rows[k].csr_wa;
        csr_wd        = rows[k].csr_wd;
        {stall, flush} = rows[k].sf;
        reg_ra        = rows[k].reg_ra;
        csr_ra        = rows[k].csr_ra;
        exp_valid     = 1'b1;
        exp_reg       = rows[k].exp_reg;
        exp_csr       = rows[k].exp_csr;
    endtask

    // --------------------
    // Main sequence
    initial begin
        int errs_before;
        void'($urandom(32'h933762e9));
        rst_n = 1'b0;
        clear_inputs();
        build_table();
        num_rows = rows.size();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < num_rows; k++) begin
            errs_before = err_cnt;
            drive_row(k);
            @(negedge clk);
            if (err_cnt == errs_before) begin
                $display("row %0d: ok", k);
            end else begin
                $display("row %0d: %0d mismatches", k, err_cnt - errs_before);
            end
        end
        clear_inputs();
        repeat (2) @(negedge clk);
        $display("Summary: %0d rows, %0d checks, %0d errors, %0d assertion failures",
                 num_rows, check_cnt, err_cnt, u_dut.u_wb_assert.fail_cnt);
        if ((err_cnt == 0) && (u_dut.u_wb_assert.fail_cnt == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (num_rows > 0);
        repeat (num_rows * 20 + RST_CYCLES) @(posedge clk);
        $display("Watchdog expired, the stimulus table did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
verilog/rooth_pkg.sv
verilog/flow_ctrl.sv
verilog/if_wb.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/wb_top.sv
dv/wb_assert.sv
dv/wb_checker.sv
dv/tb_wb_top.sv

//--- Makefile
# Verilator build and run for the write-back end testbench
VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
